// ==== vlog.f ====
+incdir+hw
+incdir+verification
hw/pitaya_pkg.sv
hw/sys_bus_decode.sv
hw/pdm_modulator.sv
hw/converter_frontend.sv
hw/bus_read_mux.sv
hw/pitaya_io_top.sv
verification/tb_pitaya_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the acquisition core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_pitaya_io \
  -f vlog.f \
  -o tb_pitaya_io

sim_out=$(./obj_dir/tb_pitaya_io)
echo "$sim_out"

if grep -q "^Testbench passed$" <<< "$sim_out"; then
  echo "Simulation OK"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi

// ==== verification/tb_pitaya_model.svh ====
/*
  Reference model of the acquisition core for the testbench,
  with typed compare tasks for bus, converter and PDM results
*/

`ifndef TB_PITAYA_MODEL_SVH
`define TB_PITAYA_MODEL_SVH

//////////////////////////////////////////////////
// Model state
//////////////////////////////////////////////////

// Level registers as written over the bus
pdm_level_t mdl_level [`PITAYA_PDM_CHN];
// Raw ADC words currently on the inputs
logic [`PITAYA_ADC_W-1:0] mdl_adc [`PITAYA_ADC_CHN];
// Check and error totals
int chk_cnt = 0;
int err_cnt = 0;

// Negative slope, sign kept and magnitude flipped
function automatic adc_sample_t adc_conv(input logic [`PITAYA_ADC_W-1:0] raw);
  return adc_sample_t'(raw ^ {1'b0, {(`PITAYA_ADC_W-1){1'b1}}});
endfunction

// Same flip back to offset code
function automatic dac_sample_t dac_conv(input dac_sample_t s);
  return s ^ {1'b0, {(`PITAYA_DAC_W-1){1'b1}}};
endfunction

// Pulses expected from a steady level
function automatic int pdm_ones(input pdm_level_t level, input int cycles);
  return (int'(level) * cycles) / `PITAYA_PDM_RANGE;
endfunction

// Region in the top nibble, index from word address bits
function automatic bus_data_t exp_read(input logic wr, input bus_addr_t addr);
  region_t  rg;
  reg_idx_t ix;
  rg = addr[15:12];
  ix = addr[5:2];
  // Writes answer with zero
  if (wr) return '0;
  if (rg == 4'd0 && ix == 4'd0) return `PITAYA_ID_WORD;
  if (rg == 4'd1 && ix < 4'd4) return {24'h0, mdl_level[ix[1:0]]};
  if (rg == 4'd2 && ix < 4'd2) return {16'h0, adc_conv(mdl_adc[ix[0]])};
  return '0;
endfunction

function automatic void model_write(input bus_addr_t addr, input bus_data_t wdata);
  // Only region 1 levels take writes
  if (addr[15:12] == 4'd1 && addr[5:2] < 4'd4) begin
    mdl_level[addr[3:2]] = wdata[`PITAYA_PDM_W-1:0];
  end
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_adc(input string name, input adc_sample_t got, input adc_sample_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_dac(input string name, input dac_sample_t got, input dac_sample_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  chk_cnt++;
  if (got != exp) begin
    err_cnt++;
    $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

`endif

// ==== verification/tb_pitaya_io.sv ====
/*
  Testbench for the acquisition core: bus reads and writes,
  converter paths, PDM density and response back-pressure
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module tb_pitaya_io import pitaya_pkg::*; ();

  // Test lengths in cycles, timeout at twice their sum
  localparam int LEN_RESET_ID     = 150;
  localparam int LEN_PDM_REGS     = 400;
  localparam int LEN_ADC          = 200;
  localparam int LEN_DAC          = 800;
  localparam int LEN_DENSITY      = 1100;
  localparam int LEN_BACKPRESSURE = 350;
  localparam int TIMEOUT_CYC = 2 * (LEN_RESET_ID + LEN_PDM_REGS + LEN_ADC +
                                    LEN_DAC + LEN_DENSITY + LEN_BACKPRESSURE);

  // Expected response, ADC reads checked as samples
  typedef struct packed {
    logic      is_adc;
    bus_data_t data;
  } exp_rsp_t;

  logic adc_clk = 1'b0;
  logic top_rst = 1'b1;
  bus_req_t  req;
  logic      req_ready;
  bus_rsp_t  rsp;
  logic      rsp_ready = 1'b1;
  logic [`PITAYA_ADC_CHN-1:0][`PITAYA_ADC_W-1:0] adc_dat;
  dac_pair_t dac;
  logic      dac_ready;
  logic [`PITAYA_DAC_W-1:0]   dac_a;
  logic [`PITAYA_DAC_W-1:0]   dac_b;
  logic [`PITAYA_PDM_CHN-1:0] pdm;

  // Outstanding responses in request order
  exp_rsp_t exp_q [$];
  logic bp_en = 1'b0;
  int   cyc_cnt = 0;

  `include "tb_pitaya_model.svh"

  pitaya_io_top pitaya_io_top_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .adc_dat_i   (adc_dat),
    .dac_i       (dac),
    .dac_ready_o (dac_ready),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .pdm_o       (pdm)
  );

  always #2 adc_clk = ~adc_clk;

  // Master side ready, random only under back-pressure
  always @(posedge adc_clk) begin
    #1;
    if (bp_en) begin
      rsp_ready = 1'($urandom_range(0, 1));
    end else begin
      rsp_ready = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Response monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    exp_rsp_t head;
    if (!top_rst && rsp.valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Response at t=%0t arrived with no request outstanding", $time);
      end else begin
        head = exp_q.pop_front();
        if (head.is_adc) begin
          check_adc("rsp_o.rdata", adc_sample_t'(rsp.rdata[15:0]),
                    adc_sample_t'(head.data[15:0]));
          check_data("rsp_o.rdata[31:16]", rsp.rdata >> 16, '0);
        end else begin
          check_data("rsp_o.rdata", rsp.rdata, head.data);
        end
      end
    end
  end

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Bus and timing helpers
  //////////////////////////////////////////////////

  // Middle address bits are ignored by the decoder
  function automatic bus_addr_t make_addr(input region_t r, input reg_idx_t ix);
    return {r, 6'($urandom), ix, 2'b00};
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  // Present one request, hold it until taken
  task automatic send_req(input logic wr, input bus_addr_t addr, input bus_data_t wdata);
    exp_rsp_t item;
    item.is_adc = !wr && (addr[15:12] == 4'd2) && (addr[5:2] < 4'd2);
    item.data   = exp_read(wr, addr);
    req.valid = 1'b1;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    @(posedge adc_clk);
    while (!req_ready) @(posedge adc_clk);
    exp_q.push_back(item);
    if (wr) model_write(addr, wdata);
    #1;
    req.valid = 1'b0;
  endtask

  // Wait for every outstanding response
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  task automatic finish_test(input string name, input int e0, input int c0);
    $display("Test %s: %0d checks, %0d errors", name, chk_cnt - c0, err_cnt - e0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int         e0;
    int         c0;
    int         gap;
    int         ones [`PITAYA_PDM_CHN];
    region_t    rg;
    reg_idx_t   ix;
    pdm_level_t lv;
    void'($urandom(86568));
    req = '0;
    dac = '0;
    adc_dat[0] = 16'($urandom);
    adc_dat[1] = 16'($urandom);
    for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) mdl_level[ch] = '0;
    mdl_adc[0] = adc_dat[0];
    mdl_adc[1] = adc_dat[1];
    repeat (16) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;
    idle(1);

    // Reset values, ID word, unmapped regions
    e0 = err_cnt;
    c0 = chk_cnt;
    check_dac("dac_a_o", dac_sample_t'(dac_a), dac_sample_t'(14'h2000));
    check_dac("dac_b_o", dac_sample_t'(dac_b), dac_sample_t'(14'h2000));
    check_count("pdm_o ones", $countones(pdm), 0);
    send_req(1'b0, make_addr(4'd0, 4'd0), '0);
    repeat (20) begin
      send_req(1'b0, make_addr(region_t'($urandom_range(3, 15)), reg_idx_t'($urandom)), '0);
    end
    drain();
    finish_test("reset_and_id", e0, c0);

    // Level registers, mixed with writes elsewhere
    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < 100; i++) begin
      rg = region_t'($urandom_range(0, 2));
      ix = reg_idx_t'($urandom_range(0, 5));
      send_req(1'($urandom_range(0, 1)), make_addr(rg, ix), bus_data_t'($urandom));
    end
    for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
      send_req(1'b0, make_addr(4'd1, reg_idx_t'(ch)), '0);
    end
    drain();
    finish_test("pdm_registers", e0, c0);

    // ADC words held, then both channels read
    e0 = err_cnt;
    c0 = chk_cnt;
    repeat (10) begin
      adc_dat[0] = 16'($urandom);
      adc_dat[1] = 16'($urandom);
      mdl_adc[0] = adc_dat[0];
      mdl_adc[1] = adc_dat[1];
      idle(3);
      send_req(1'b0, make_addr(4'd2, 4'd0), '0);
      send_req(1'b0, make_addr(4'd2, 4'd1), '0);
      send_req(1'b0, make_addr(4'd2, 4'd2), '0);
      drain();
    end
    finish_test("adc_conversion", e0, c0);

    // DAC pairs with random idle gaps
    e0 = err_cnt;
    c0 = chk_cnt;
    for (int i = 0; i < 200; i++) begin
      gap = $urandom_range(0, 2);
      idle(gap);
      dac.valid = 1'b1;
      dac.a = dac_sample_t'($urandom);
      dac.b = dac_sample_t'($urandom);
      @(posedge adc_clk);
      while (!dac_ready) @(posedge adc_clk);
      #1;
      dac.valid = 1'b0;
      check_dac("dac_a_o", dac_sample_t'(dac_a), dac_conv(dac.a));
      check_dac("dac_b_o", dac_sample_t'(dac_b), dac_conv(dac.b));
    end
    finish_test("dac_conversion", e0, c0);

    // Pulse counts over one full modulus window
    e0 = err_cnt;
    c0 = chk_cnt;
    for (int r = 0; r < 4; r++) begin
      for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
        lv = pdm_level_t'($urandom);
        // First round covers both ends of the scale
        if (r == 0 && ch == 0) lv = 8'd0;
        if (r == 0 && ch == 1) lv = 8'hFF;
        send_req(1'b1, make_addr(4'd1, reg_idx_t'(ch)), {24'h0, lv});
        ones[ch] = 0;
      end
      drain();
      idle(3);
      repeat (`PITAYA_PDM_RANGE) begin
        @(posedge adc_clk);
        #1;
        for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
          if (pdm[ch]) ones[ch]++;
        end
      end
      for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
        check_count($sformatf("pdm_o[%0d] ones", ch), ones[ch],
                    pdm_ones(mdl_level[ch], `PITAYA_PDM_RANGE));
      end
    end
    finish_test("pdm_density", e0, c0);

    // Reads while the master stalls responses at random
    e0 = err_cnt;
    c0 = chk_cnt;
    bp_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      rg = region_t'($urandom_range(0, 3));
      ix = reg_idx_t'($urandom_range(0, 5));
      send_req(1'b0, make_addr(rg, ix), '0);
      idle($urandom_range(0, 1));
    end
    drain();
    bp_en = 1'b0;
    idle(2);
    finish_test("backpressure", e0, c0);

    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/pitaya_io_top.sv ====
/*
  Acquisition and generation data path, bus decoder feeding
  PDM and converter units, read responses collected at the end
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module pitaya_io_top import pitaya_pkg::*; (
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  // System bus
  input  bus_req_t                                    req_i,
  output logic                                        req_ready_o,
  output bus_rsp_t                                    rsp_o,
  input  logic                                        rsp_ready_i,
  // ADC raw words
  input  logic [`PITAYA_ADC_CHN-1:0][`PITAYA_ADC_W-1:0] adc_dat_i,
  // DAC stream and outputs
  input  dac_pair_t                                   dac_i,
  output logic                                        dac_ready_o,
  output logic [`PITAYA_DAC_W-1:0]                    dac_a_o,
  output logic [`PITAYA_DAC_W-1:0]                    dac_b_o,
  // Pulse-density outputs
  output logic [`PITAYA_PDM_CHN-1:0]                  pdm_o
);

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  // Decoded item and its handshake
  dec_item_t dec_item;
  logic      dec_ready;
  // Level write strobe
  pdm_wr_t   pdm_wr;
  // Read path sources
  pdm_level_t  [`PITAYA_PDM_CHN-1:0] pdm_levels;
  adc_sample_t [`PITAYA_ADC_CHN-1:0] adc_samples;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  sys_bus_decode sys_bus_decode_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .dec_o       (dec_item),
    .dec_ready_i (dec_ready),
    .pdm_wr_o    (pdm_wr)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  pdm_modulator pdm_modulator_i (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .pdm_wr_i (pdm_wr),
    .levels_o (pdm_levels),
    .pdm_o    (pdm_o)
  );

  converter_frontend converter_frontend_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .samples_o   (adc_samples),
    .dac_i       (dac_i),
    .dac_ready_o (dac_ready_o),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////

  bus_read_mux bus_read_mux_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .dec_i       (dec_item),
    .dec_ready_o (dec_ready),
    .levels_i    (pdm_levels),
    .samples_i   (adc_samples),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

`default_nettype wire

// ==== hw/bus_read_mux.sv ====
/*
  Read response stage: picks read data by source and index,
  registers one response and holds it under back-pressure
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module bus_read_mux import pitaya_pkg::*; (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  dec_item_t                          dec_i,
  output logic                               dec_ready_o,
  input  pdm_level_t  [`PITAYA_PDM_CHN-1:0] levels_i,
  input  adc_sample_t [`PITAYA_ADC_CHN-1:0] samples_i,
  output bus_rsp_t                           rsp_o,
  input  logic                               rsp_ready_i
);

  // Index bits that address a channel
  localparam int unsigned PDM_IDX_W = $clog2(`PITAYA_PDM_CHN);
  localparam int unsigned ADC_IDX_W = $clog2(`PITAYA_ADC_CHN);

  // Response register
  logic      rsp_vld_q;
  bus_data_t rsp_data_q;
  // Selected read word
  bus_data_t rd_data;

  //////////////////////////////////////////////////
  // Read data select
  //////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (dec_i.sel)
      SEL_ID: begin
        if (dec_i.idx == '0) begin
          rd_data = `PITAYA_ID_WORD;
        end
      end
      SEL_PDM: begin
        // Levels zero-extended
        if (dec_i.idx < reg_idx_t'(`PITAYA_PDM_CHN)) begin
          rd_data = bus_data_t'(levels_i[dec_i.idx[PDM_IDX_W-1:0]]);
        end
      end
      SEL_ADC: begin
        // Concatenation keeps the sample unsigned
        if (dec_i.idx < reg_idx_t'(`PITAYA_ADC_CHN)) begin
          rd_data = {{(`PITAYA_BUS_DATA_W-`PITAYA_ADC_W){1'b0}},
                     samples_i[dec_i.idx[ADC_IDX_W-1:0]]};
        end
      end
      // Writes and unmapped regions
      default: rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////

  // Empty, or current response taken this edge
  assign dec_ready_o = !rsp_vld_q || rsp_ready_i;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      rsp_vld_q <= 1'b0;
    end else if (dec_ready_o) begin
      rsp_vld_q <= dec_i.valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (dec_ready_o && dec_i.valid) begin
      rsp_data_q <= rd_data;
    end
  end

  assign rsp_o.valid = rsp_vld_q;
  assign rsp_o.rdata = rsp_data_q;

  // Stalled response stays put
  a_rsp_stable: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (rsp_o.valid && !rsp_ready_i) |=> $stable(rsp_o)
  );

endmodule

`default_nettype wire

// ==== hw/converter_frontend.sv ====
/*
  Converter front end, ADC capture into two's complement and
  DAC pair acceptance back into offset code, both negative slope
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module converter_frontend import pitaya_pkg::*; (
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  // ADC side
  input  logic [`PITAYA_ADC_CHN-1:0][`PITAYA_ADC_W-1:0] adc_dat_i,
  output adc_sample_t [`PITAYA_ADC_CHN-1:0]           samples_o,
  // DAC side
  input  dac_pair_t                                   dac_i,
  output logic                                        dac_ready_o,
  output logic [`PITAYA_DAC_W-1:0]                    dac_a_o,
  output logic [`PITAYA_DAC_W-1:0]                    dac_b_o
);

  // Mid-scale code, MSB set
  localparam logic [`PITAYA_DAC_W-1:0] DAC_RST = {1'b1, {(`PITAYA_DAC_W-1){1'b0}}};

  // Raw ADC words, one per channel
  logic [`PITAYA_ADC_CHN-1:0][`PITAYA_ADC_W-1:0] adc_raw_q;
  // Ready once out of reset
  logic dac_rdy_q;
  logic dac_load;

  //////////////////////////////////////////////////
  // ADC capture
  //////////////////////////////////////////////////

  // Single input register stage
  always_ff @(posedge adc_clk) begin
    adc_raw_q <= adc_dat_i;
  end

  // Keep sign, flip magnitude bits
  for (genvar ch = 0; ch < `PITAYA_ADC_CHN; ch++) begin : g_adc
    assign samples_o[ch] = {adc_raw_q[ch][`PITAYA_ADC_W-1],
                            ~adc_raw_q[ch][`PITAYA_ADC_W-2:0]};
  end

  //////////////////////////////////////////////////
  // DAC acceptance
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_rdy_q <= 1'b0;
    end else begin
      dac_rdy_q <= 1'b1;
    end
  end

  assign dac_ready_o = dac_rdy_q;
  assign dac_load    = dac_i.valid && dac_rdy_q;

  // Signed back to offset code, same bit flip
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_a_o <= DAC_RST;
      dac_b_o <= DAC_RST;
    end else if (dac_load) begin
      dac_a_o <= {dac_i.a[`PITAYA_DAC_W-1], ~dac_i.a[`PITAYA_DAC_W-2:0]};
      dac_b_o <= {dac_i.b[`PITAYA_DAC_W-1], ~dac_i.b[`PITAYA_DAC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

// ==== hw/pdm_modulator.sv ====
/*
  Four PDM channels, level registers written over the bus and
  first-order accumulators driving the registered outputs
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module pdm_modulator import pitaya_pkg::*; (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  input  pdm_wr_t                           pdm_wr_i,
  output pdm_level_t [`PITAYA_PDM_CHN-1:0] levels_o,
  output logic       [`PITAYA_PDM_CHN-1:0] pdm_o
);

  // Sum needs one carry bit over the level
  localparam int unsigned SUM_W = `PITAYA_PDM_W + 1;
  localparam logic [SUM_W-1:0] RANGE = SUM_W'(`PITAYA_PDM_RANGE);

  // Bus visible levels
  pdm_level_t [`PITAYA_PDM_CHN-1:0] level_q;
  // Running remainder per channel
  pdm_level_t [`PITAYA_PDM_CHN-1:0] acc_q;

  assign levels_o = level_q;

  //////////////////////////////////////////////////
  // Level registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      level_q <= '0;
    end else if (pdm_wr_i.en) begin
      level_q[pdm_wr_i.idx] <= pdm_wr_i.level;
    end
  end

  //////////////////////////////////////////////////
  // Accumulators
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin : g_chn
    logic [SUM_W-1:0] sum;

    assign sum = {1'b0, acc_q[ch]} + {1'b0, level_q[ch]};

    // Overflow past the range emits a pulse
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc_q[ch] <= '0;
        pdm_o[ch] <= 1'b0;
      end else if (sum >= RANGE) begin
        acc_q[ch] <= pdm_level_t'(sum - RANGE);
        pdm_o[ch] <= 1'b1;
      end else begin
        acc_q[ch] <= pdm_level_t'(sum);
        pdm_o[ch] <= 1'b0;
      end
    end

    // Remainder never reaches the modulus
    a_acc_range: assert property (
      @(posedge adc_clk) disable iff (top_rst)
      ({1'b0, acc_q[ch]} < RANGE)
    );
  end

endmodule

`default_nettype wire

// ==== hw/sys_bus_decode.sv ====
/*
  Bus request stage: one registered request, split into region
  and register index, with a level strobe for PDM writes
*/

`timescale 1ns/1ns
`default_nettype none

`include "pitaya_settings.svh"

module sys_bus_decode import pitaya_pkg::*; (
  input  logic      adc_clk,
  input  logic      top_rst,
  input  bus_req_t  req_i,
  output logic      req_ready_o,
  output dec_item_t dec_o,
  input  logic      dec_ready_i,
  output pdm_wr_t   pdm_wr_o
);

  // Region map
  localparam region_t REGION_ID  = region_t'(0);
  localparam region_t REGION_PDM = region_t'(1);
  localparam region_t REGION_ADC = region_t'(2);

  // Held item
  logic       item_vld_q;
  read_sel_e  item_sel_q;
  reg_idx_t   item_idx_q;
  // Pending level write carried with the item
  logic       pdm_hit_q;
  pdm_level_t pdm_level_q;

  // Fields of the incoming request
  region_t    req_region;
  reg_idx_t   req_idx;
  read_sel_e  req_sel;
  logic       req_pdm_hit;
  logic       req_load;

  //////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////

  assign req_region = req_i.addr[`PITAYA_BUS_ADDR_W-1 -: `PITAYA_REGION_W];
  // Word addressed, byte bits dropped
  assign req_idx = req_i.addr[2 +: $bits(reg_idx_t)];

  // Writes read back nothing
  always_comb begin
    if (req_i.write) begin
      req_sel = SEL_NONE;
    end else begin
      case (req_region)
        REGION_ID:  req_sel = SEL_ID;
        REGION_PDM: req_sel = SEL_PDM;
        REGION_ADC: req_sel = SEL_ADC;
        default:    req_sel = SEL_NONE;
      endcase
    end
  end

  // Only level registers take writes
  assign req_pdm_hit = req_i.write && (req_region == REGION_PDM) &&
                       (req_idx < reg_idx_t'(`PITAYA_PDM_CHN));

  //////////////////////////////////////////////////
  // Item register
  //////////////////////////////////////////////////

  // Free slot, or the held item leaves this edge
  assign req_ready_o = !item_vld_q || dec_ready_i;
  assign req_load    = req_ready_o && req_i.valid;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      item_vld_q <= 1'b0;
    end else if (req_ready_o) begin
      item_vld_q <= req_i.valid;
    end
  end

  // Payload follows the valid bit
  always_ff @(posedge adc_clk) begin
    if (req_load) begin
      item_sel_q  <= req_sel;
      item_idx_q  <= req_idx;
      pdm_hit_q   <= req_pdm_hit;
      pdm_level_q <= req_i.wdata[`PITAYA_PDM_W-1:0];
    end
  end

  assign dec_o.valid = item_vld_q;
  assign dec_o.sel   = item_sel_q;
  assign dec_o.idx   = item_idx_q;

  // Strobe on the hand-over edge only
  assign pdm_wr_o.en    = item_vld_q && dec_ready_i && pdm_hit_q;
  assign pdm_wr_o.idx   = item_idx_q[$bits(pdm_idx_t)-1:0];
  assign pdm_wr_o.level = pdm_level_q;

  // Held item must not move until taken
  a_dec_stable: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (dec_o.valid && !dec_ready_i) |=> $stable(dec_o)
  );

endmodule

`default_nettype wire

// ==== hw/pitaya_pkg.sv ====
/*
  Shared types of the acquisition core: data vectors,
  bus request and response structs, decoded items
*/

`default_nettype none

`include "pitaya_settings.svh"

package pitaya_pkg;

  //////////////////////////////////////////////////
  // Plain vectors
  //////////////////////////////////////////////////

  // Bus address and data
  typedef logic [`PITAYA_BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [`PITAYA_BUS_DATA_W-1:0] bus_data_t;

  // Region number, top address bits
  typedef logic [`PITAYA_REGION_W-1:0] region_t;
  // Register inside a region, word address low bits
  typedef logic [3:0] reg_idx_t;

  // Converter samples, two's complement
  typedef logic signed [`PITAYA_ADC_W-1:0] adc_sample_t;
  typedef logic signed [`PITAYA_DAC_W-1:0] dac_sample_t;

  // PDM level and channel number
  typedef logic [`PITAYA_PDM_W-1:0] pdm_level_t;
  typedef logic [$clog2(`PITAYA_PDM_CHN)-1:0] pdm_idx_t;

  //////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////

  // Request from the bus master
  typedef struct packed {
    logic      valid;
    logic      write;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  // One response per request
  typedef struct packed {
    logic      valid;
    bus_data_t rdata;
  } bus_rsp_t;

  // Read data source
  typedef enum logic [1:0] {
    SEL_ID,
    SEL_PDM,
    SEL_ADC,
    SEL_NONE
  } read_sel_e;

  // Decoder to response stage
  typedef struct packed {
    logic      valid;
    read_sel_e sel;
    reg_idx_t  idx;
  } dec_item_t;

  // Level update, single cycle strobe
  typedef struct packed {
    logic       en;
    pdm_idx_t   idx;
    pdm_level_t level;
  } pdm_wr_t;

  // DAC sample pair stream
  typedef struct packed {
    logic        valid;
    dac_sample_t a;
    dac_sample_t b;
  } dac_pair_t;

endpackage

`default_nettype wire

// ==== hw/pitaya_settings.svh ====
/*
  Acquisition core settings: bus, converter and PDM widths,
  channel counts and the identification word
*/

`ifndef PITAYA_SETTINGS_SVH
`define PITAYA_SETTINGS_SVH

//////////////////////////////////////////////////
// System bus
//////////////////////////////////////////////////

// Byte address and data word
`define PITAYA_BUS_ADDR_W 16
`define PITAYA_BUS_DATA_W 32
// Top address bits pick one of 16 regions
`define PITAYA_REGION_W 4

//////////////////////////////////////////////////
// Converters
//////////////////////////////////////////////////

// Two ADC inputs, 16-bit raw words
`define PITAYA_ADC_CHN 2
`define PITAYA_ADC_W 16
// 14-bit DAC samples
`define PITAYA_DAC_W 14

//////////////////////////////////////////////////
// PDM outputs
//////////////////////////////////////////////////

`define PITAYA_PDM_CHN 4
`define PITAYA_PDM_W 8
// Accumulator wraps at this value
`define PITAYA_PDM_RANGE 255

// Returned by region 0 index 0
`define PITAYA_ID_WORD 32'h5254_4941

`endif
